/* files.f */
+incdir+hdl
hdl/qt_types_pkg.sv
hdl/host_bus_pkg.sv
hdl/qt_port_if.sv
hdl/status_regs.sv
hdl/port_b_arbiter.sv
hdl/queue_table_column.sv
hdl/queue_switcher.sv
hdl/pcie_queue_top.sv
tb/queue_table_checker.sv
tb/tb_pcie_queue_top.sv

/* hdl/host_bus_pkg.sv */
`include "qt_params.svh"

package host_bus_pkg;

    // control register at status word address 0
    typedef struct packed {
        logic [4:0]  nb_queues;
        logic [25:0] rb_size;
        logic        disable_pcie;
    } ctrl_reg_s;

    // one status read of a single table column
    typedef struct packed {
        qt_types_pkg::qt_col_t    col;
        qt_types_pkg::queue_idx_t queue;
    } stat_rd_req_s;

endpackage

/* hdl/pcie_queue_top.sv */
`timescale 1ns/1ps
`include "qt_params.svh"

module pcie_queue_top (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    // host register pages
    input  logic [`HOST_AWIDTH-1:0]    pcie_address,
    input  logic                       pcie_write,
    input  logic                       pcie_read,
    input  logic [`HOST_DWIDTH-1:0]    pcie_writedata,
    input  logic [`HOST_DWIDTH/8-1:0]  pcie_byteenable,
    output logic [`HOST_DWIDTH-1:0]    pcie_readdata,
    output logic                       pcie_readdatavalid,
    // status bus
    input  logic [`STAT_AWIDTH-1:0]    status_addr,
    input  logic                       status_read,
    input  logic                       status_write,
    input  logic [31:0]                status_writedata,
    output logic [31:0]                status_readdata,
    output logic                       status_readdata_valid,
    // DMA engine side
    input  logic                       dma_done,
    input  logic [`QT_DWIDTH-1:0]      new_tail,
    output logic [`QT_AWIDTH-1:0]      curr_queue,
    output logic [`QT_DWIDTH-1:0]      curr_head,
    output logic [`QT_DWIDTH-1:0]      curr_tail,
    output logic [63:0]                curr_kmem_addr,
    output logic                       switch_done,
    output logic                       disable_pcie,
    output logic [25:0]                rb_size
);
    import qt_types_pkg::*;
    import host_bus_pkg::*;

    ctrl_reg_s             ctrl;
    logic                  stat_req_valid;
    stat_rd_req_s          stat_req;
    logic                  stat_rsp_valid;
    logic [`QT_DWIDTH-1:0] stat_rsp_data;
    logic [`QT_COLS-1:0]   upd_mask;
    queue_idx_t            upd_queue;
    queue_entry_u          upd_entry;
    queue_entry_u          curr_entry;

    qt_port_if port_a [`QT_COLS] ();
    qt_port_if port_b [`QT_COLS] ();

    status_regs u_status_regs (
        .pcie_clk, .pcie_reset_n,
        .status_addr, .status_read, .status_write, .status_writedata,
        .status_readdata, .status_readdata_valid,
        .ctrl, .stat_req_valid, .stat_req, .stat_rsp_valid, .stat_rsp_data
    );

    port_b_arbiter u_port_b_arbiter (
        .pcie_clk, .pcie_reset_n,
        .pcie_address, .pcie_write, .pcie_read, .pcie_writedata, .pcie_byteenable,
        .pcie_readdata, .pcie_readdatavalid,
        .stat_req_valid, .stat_req, .stat_rsp_valid, .stat_rsp_data,
        .upd_mask, .upd_queue, .upd_entry,
        .port_b (port_b)
    );

    queue_switcher u_queue_switcher (
        .pcie_clk, .pcie_reset_n,
        .ctrl, .dma_done, .new_tail,
        .upd_mask, .upd_queue, .upd_entry,
        .port_a (port_a),
        .curr_queue, .curr_entry, .switch_done
    );

    for (genvar c = 0; c < `QT_COLS; c++) begin : g_col
        queue_table_column u_col (
            .pcie_clk,
            .port_a (port_a[c]),
            .port_b (port_b[c])
        );
    end

    assign curr_head      = curr_entry.f.head;
    assign curr_tail      = curr_entry.f.tail;
    assign curr_kmem_addr = {curr_entry.f.h_addr, curr_entry.f.l_addr};
    assign disable_pcie   = ctrl.disable_pcie;
    assign rb_size        = ctrl.rb_size;

endmodule

/* hdl/port_b_arbiter.sv */
`timescale 1ns/1ps
`include "qt_params.svh"

module port_b_arbiter (
    input  logic                        pcie_clk,
    input  logic                        pcie_reset_n,
    input  logic [`HOST_AWIDTH-1:0]     pcie_address,
    input  logic                        pcie_write,
    input  logic                        pcie_read,
    input  logic [`HOST_DWIDTH-1:0]     pcie_writedata,
    input  logic [`HOST_DWIDTH/8-1:0]   pcie_byteenable,
    output logic [`HOST_DWIDTH-1:0]     pcie_readdata,
    output logic                        pcie_readdatavalid,
    input  logic                        stat_req_valid,
    input  host_bus_pkg::stat_rd_req_s  stat_req,
    output logic                        stat_rsp_valid,
    output logic [`QT_DWIDTH-1:0]       stat_rsp_data,
    output logic [`QT_COLS-1:0]         upd_mask,
    output qt_types_pkg::queue_idx_t    upd_queue,
    output qt_types_pkg::queue_entry_u  upd_entry,
    qt_port_if.master                   port_b [`QT_COLS]
);
    import qt_types_pkg::*;
    import host_bus_pkg::*;

    queue_idx_t            page_idx;
    queue_idx_t            b_addr [`QT_COLS];
    logic [`QT_DWIDTH-1:0] b_wr_data [`QT_COLS];
    logic [`QT_COLS-1:0]   b_wr_en;
    logic [`QT_COLS-1:0]   b_rd_en;
    queue_entry_u          rd_entry;

    logic                  host_rd_pend;
    queue_idx_t            host_rd_queue;
    logic                  stat_rd_pend;
    stat_rd_req_s          stat_rd_q;

    // read tags, stage 2 lines up with the BRAM output data
    logic [2:0]            tag_host;
    logic [2:0]            tag_stat;
    qt_col_t               tag_col [3];

    assign page_idx = pcie_address[`PAGE_LSB +: `QT_AWIDTH];

    // priority: host writes, then host reads, then status reads
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            b_wr_en            <= '0;
            b_rd_en            <= '0;
            upd_mask           <= '0;
            host_rd_pend       <= 1'b0;
            stat_rd_pend       <= 1'b0;
            tag_host           <= '0;
            tag_stat           <= '0;
            pcie_readdatavalid <= 1'b0;
            stat_rsp_valid     <= 1'b0;
        end else begin
            b_wr_en  <= '0;
            b_rd_en  <= '0;
            upd_mask <= '0;
            tag_host <= {tag_host[1:0], 1'b0};
            tag_stat <= {tag_stat[1:0], 1'b0};
            if (pcie_write) begin
                // the tail belongs to the switcher, dword 0 is skipped
                for (int c = 1; c < `QT_COLS; c++) begin
                    if (&pcie_byteenable[4*c +: 4]) begin
                        b_wr_en[c]  <= 1'b1;
                        upd_mask[c] <= 1'b1;
                    end
                end
            end else if (host_rd_pend) begin
                b_rd_en      <= '1;
                tag_host[0]  <= 1'b1;
                host_rd_pend <= 1'b0;
            end else if (stat_rd_pend) begin
                b_rd_en[stat_rd_q.col] <= 1'b1;
                tag_stat[0]            <= 1'b1;
                stat_rd_pend           <= 1'b0;
            end
            if (pcie_read) begin
                host_rd_pend <= 1'b1;
            end
            if (stat_req_valid) begin
                stat_rd_pend <= 1'b1;
            end
            pcie_readdatavalid <= tag_host[2];
            stat_rsp_valid     <= tag_stat[2];
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_write) begin
            for (int c = 0; c < `QT_COLS; c++) begin
                b_addr[c]    <= page_idx;
                b_wr_data[c] <= pcie_writedata[`QT_DWIDTH*c +: `QT_DWIDTH];
            end
            upd_queue <= page_idx;
            upd_entry <= pcie_writedata;
        end else if (host_rd_pend) begin
            for (int c = 0; c < `QT_COLS; c++) begin
                b_addr[c] <= host_rd_queue;
            end
        end else if (stat_rd_pend) begin
            b_addr[stat_rd_q.col] <= stat_rd_q.queue;
        end
        if (pcie_read) begin
            host_rd_queue <= page_idx;
        end
        if (stat_req_valid) begin
            stat_rd_q <= stat_req;
        end
        tag_col[0] <= stat_rd_q.col;
        tag_col[1] <= tag_col[0];
        tag_col[2] <= tag_col[1];
        if (tag_host[2]) begin
            pcie_readdata <= rd_entry;
        end
        if (tag_stat[2]) begin
            stat_rsp_data <= rd_entry.col[tag_col[2]];
        end
    end

    for (genvar c = 0; c < `QT_COLS; c++) begin : g_port
        assign port_b[c].addr    = b_addr[c];
        assign port_b[c].wr_data = b_wr_data[c];
        assign port_b[c].wr_en   = b_wr_en[c];
        assign port_b[c].rd_en   = b_rd_en[c];
        assign rd_entry.col[c]   = port_b[c].rd_data;
    end

endmodule

/* hdl/qt_params.svh */
`ifndef QT_PARAMS_SVH
`define QT_PARAMS_SVH

// queue table geometry
`define QT_DEPTH 16
`define QT_AWIDTH 4
`define QT_DWIDTH 32
`define QT_COLS 4

// host bus
`define HOST_DWIDTH 128
`define HOST_AWIDTH 20

// one 4 KiB register page per queue
`define PAGE_LSB 12

// status bus word address
`define STAT_AWIDTH 8

`endif

/* hdl/qt_port_if.sv */
`timescale 1ns/1ps
`include "qt_params.svh"

// one BRAM port of one table column
interface qt_port_if;

    logic [`QT_AWIDTH-1:0] addr;
    logic [`QT_DWIDTH-1:0] wr_data;
    logic                  wr_en;
    logic                  rd_en;
    // valid two cycles after rd_en
    logic [`QT_DWIDTH-1:0] rd_data;

    modport master (
        output addr, wr_data, wr_en, rd_en,
        input  rd_data
    );

    modport mem (
        input  addr, wr_data, wr_en, rd_en,
        output rd_data
    );

endinterface

/* hdl/qt_types_pkg.sv */
`include "qt_params.svh"

package qt_types_pkg;

    // column numbers, also the dword position inside an entry
    typedef enum logic [1:0] {
        col_tail,
        col_head,
        col_l_addr,
        col_h_addr
    } qt_col_t;

    typedef logic [`QT_AWIDTH-1:0] queue_idx_t;

    // tail sits in the low dword
    typedef struct packed {
        logic [`QT_DWIDTH-1:0] h_addr;
        logic [`QT_DWIDTH-1:0] l_addr;
        logic [`QT_DWIDTH-1:0] head;
        logic [`QT_DWIDTH-1:0] tail;
    } queue_entry_s;

    typedef union packed {
        queue_entry_s                         f;
        logic [`QT_COLS-1:0][`QT_DWIDTH-1:0]  col;
    } queue_entry_u;

endpackage

/* hdl/queue_switcher.sv */
`timescale 1ns/1ps
`include "qt_params.svh"

module queue_switcher (
    input  logic                        pcie_clk,
    input  logic                        pcie_reset_n,
    input  host_bus_pkg::ctrl_reg_s     ctrl,
    input  logic                        dma_done,
    input  logic [`QT_DWIDTH-1:0]       new_tail,
    input  logic [`QT_COLS-1:0]         upd_mask,
    input  qt_types_pkg::queue_idx_t    upd_queue,
    input  qt_types_pkg::queue_entry_u  upd_entry,
    qt_port_if.master                   port_a [`QT_COLS],
    output qt_types_pkg::queue_idx_t    curr_queue,
    output qt_types_pkg::queue_entry_u  curr_entry,
    output logic                        switch_done
);
    import qt_types_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_bram_wait1,
        st_bram_wait2,
        st_switch
    } state_t;

    state_t                state;
    queue_idx_t            next_queue;
    queue_idx_t            a_addr;
    logic                  a_wr_en;
    logic                  a_rd_en;
    logic [`QT_DWIDTH-1:0] tail_latched;
    queue_entry_u          rd_entry;

    // wraps to 0 after nb_queues-1
    assign next_queue = ({1'b0, curr_queue} + 5'd1 >= ctrl.nb_queues) ? '0 :
                        curr_queue + 1'b1;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state       <= st_idle;
            curr_queue  <= '0;
            curr_entry  <= '0;
            a_wr_en     <= 1'b0;
            a_rd_en     <= 1'b0;
            switch_done <= 1'b0;
        end else begin
            a_wr_en     <= 1'b0;
            a_rd_en     <= 1'b0;
            switch_done <= 1'b0;
            // host updates to the active queue apply right away
            if (upd_queue == curr_queue) begin
                if (upd_mask[col_head]) begin
                    curr_entry.f.head <= upd_entry.f.head;
                end
                if (upd_mask[col_l_addr]) begin
                    curr_entry.f.l_addr <= upd_entry.f.l_addr;
                end
                if (upd_mask[col_h_addr]) begin
                    curr_entry.f.h_addr <= upd_entry.f.h_addr;
                end
            end
            case (state)
                st_idle: begin
                    if (dma_done) begin
                        a_rd_en <= 1'b1;
                        state   <= st_bram_wait1;
                    end
                end
                st_bram_wait1: state <= st_bram_wait2;
                st_bram_wait2: state <= st_switch;
                st_switch: begin
                    // store the returned tail of the queue we leave
                    a_wr_en             <= 1'b1;
                    curr_queue          <= a_addr;
                    curr_entry.f.head   <= rd_entry.f.head;
                    curr_entry.f.l_addr <= rd_entry.f.l_addr;
                    curr_entry.f.h_addr <= rd_entry.f.h_addr;
                    // a single queue keeps its own tail since the table copy is stale
                    curr_entry.f.tail   <= (ctrl.nb_queues > 5'd1) ? rd_entry.f.tail :
                                           tail_latched;
                    switch_done         <= 1'b1;
                    state               <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (state == st_idle && dma_done) begin
            a_addr       <= next_queue;
            tail_latched <= new_tail;
        end else if (state == st_switch) begin
            a_addr <= curr_queue;
        end
    end

    for (genvar c = 0; c < `QT_COLS; c++) begin : g_port
        assign port_a[c].addr    = a_addr;
        assign port_a[c].wr_data = tail_latched;
        assign port_a[c].wr_en   = a_wr_en & (c == int'(col_tail));
        assign port_a[c].rd_en   = a_rd_en;
        assign rd_entry.col[c]   = port_a[c].rd_data;
    end

endmodule

/* hdl/queue_table_column.sv */
`timescale 1ns/1ps
`include "qt_params.svh"

// true dual-port column, both ports read with two register stages
module queue_table_column (
    input  logic    pcie_clk,
    qt_port_if.mem  port_a,
    qt_port_if.mem  port_b
);

    logic [`QT_DWIDTH-1:0] mem [`QT_DEPTH];
    logic [`QT_DWIDTH-1:0] a_q1;
    logic [`QT_DWIDTH-1:0] a_q2;
    logic [`QT_DWIDTH-1:0] b_q1;
    logic [`QT_DWIDTH-1:0] b_q2;

    // BRAM init content
    initial begin
        for (int i = 0; i < `QT_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge pcie_clk) begin
        if (port_a.wr_en) begin
            mem[port_a.addr] <= port_a.wr_data;
        end
        if (port_b.wr_en) begin
            mem[port_b.addr] <= port_b.wr_data;
        end
    end

    // read returns the old word on a same-cycle write
    always_ff @(posedge pcie_clk) begin
        if (port_a.rd_en) begin
            a_q1 <= mem[port_a.addr];
        end
        if (port_b.rd_en) begin
            b_q1 <= mem[port_b.addr];
        end
        a_q2 <= a_q1;
        b_q2 <= b_q1;
    end

    assign port_a.rd_data = a_q2;
    assign port_b.rd_data = b_q2;

endmodule

/* hdl/status_regs.sv */
`timescale 1ns/1ps
`include "qt_params.svh"

module status_regs (
    input  logic                        pcie_clk,
    input  logic                        pcie_reset_n,
    input  logic [`STAT_AWIDTH-1:0]     status_addr,
    input  logic                        status_read,
    input  logic                        status_write,
    input  logic [31:0]                 status_writedata,
    output logic [31:0]                 status_readdata,
    output logic                        status_readdata_valid,
    output host_bus_pkg::ctrl_reg_s     ctrl,
    output logic                        stat_req_valid,
    output host_bus_pkg::stat_rd_req_s  stat_req,
    input  logic                        stat_rsp_valid,
    input  logic [31:0]                 stat_rsp_data
);
    import qt_types_pkg::*;
    import host_bus_pkg::*;

    logic [`STAT_AWIDTH-1:0] addr_r;
    logic                    read_r;
    logic                    write_r;
    logic [31:0]             writedata_r;
    logic [`STAT_AWIDTH-1:0] word_idx;

    // word n > 0 is column (n-1) mod 4 of queue (n-1)/4
    assign word_idx = addr_r - 1'b1;

    // input stage of the status bus
    always_ff @(posedge pcie_clk) begin
        addr_r      <= status_addr;
        writedata_r <= status_writedata;
        if (!pcie_reset_n) begin
            read_r  <= 1'b0;
            write_r <= 1'b0;
        end else begin
            read_r  <= status_read;
            write_r <= status_write;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            ctrl                  <= '0;
            status_readdata_valid <= 1'b0;
            stat_req_valid        <= 1'b0;
        end else begin
            status_readdata_valid <= stat_rsp_valid || (read_r && addr_r == '0);
            stat_req_valid        <= read_r && addr_r != '0;
            if (write_r && addr_r == '0) begin
                ctrl <= ctrl_reg_s'(writedata_r);
            end
        end
    end

    // table response wins over a control read, only one read is outstanding anyway
    always_ff @(posedge pcie_clk) begin
        if (stat_rsp_valid) begin
            status_readdata <= stat_rsp_data;
        end else if (read_r) begin
            status_readdata <= ctrl;
        end
        if (read_r) begin
            stat_req.col   <= qt_col_t'(word_idx[1:0]);
            stat_req.queue <= word_idx[2 +: `QT_AWIDTH];
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the queue table testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_pcie_queue_top -Mdir obj_dir

./obj_dir/Vtb_pcie_queue_top > sim.log 2>&1
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
else
    exit 1
fi

/* tb/queue_table_checker.sv */
`timescale 1ns/1ps

module queue_table_checker (
    input logic        pcie_clk,
    input logic        pcie_reset_n,
    input logic        pcie_read,
    input logic        pcie_readdatavalid,
    input logic        dma_done,
    input logic [31:0] new_tail,
    input logic        switch_done,
    input logic [3:0]  curr_queue,
    input logic [3:0]  a_wr_en,
    input logic [3:0]  a_addr,
    input logic [31:0] a_wr_data
);

    logic rd_outstanding;

    // one host read may be in flight
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_outstanding <= 1'b0;
        end else if (pcie_read) begin
            rd_outstanding <= 1'b1;
        end else if (pcie_readdatavalid) begin
            rd_outstanding <= 1'b0;
        end
    end

    a_rdv_needs_read: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        pcie_readdatavalid |-> rd_outstanding)
        else $error("host readdatavalid without an outstanding read");

    a_switch_after_dma: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        dma_done |-> ##4 switch_done)
        else $error("switch_done did not follow dma_done by 4 cycles");

    a_switch_has_dma: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        switch_done |-> $past(dma_done, 4))
        else $error("switch_done without dma_done 4 cycles before");

    // port A stores only the returned tail into the tail column of the queue it leaves
    a_port_a_tail_only: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        (|a_wr_en) |-> (a_wr_en == 4'b0001 && a_addr == $past(curr_queue) &&
                        a_wr_data == $past(new_tail, 4)))
        else $error("port A write other than the returned tail of the previous queue");

endmodule

bind pcie_queue_top queue_table_checker u_checker (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .pcie_read          (pcie_read),
    .pcie_readdatavalid (pcie_readdatavalid),
    .dma_done           (dma_done),
    .new_tail           (new_tail),
    .switch_done        (switch_done),
    .curr_queue         (curr_queue),
    .a_wr_en            ({port_a[3].wr_en, port_a[2].wr_en,
                          port_a[1].wr_en, port_a[0].wr_en}),
    .a_addr             (port_a[0].addr),
    .a_wr_data          (port_a[0].wr_data)
);

/* tb/tb_pcie_queue_top.sv */
`timescale 1ns/1ps
`include "qt_params.svh"

module tb_pcie_queue_top;

    logic                        pcie_clk;
    logic                        pcie_reset_n;
    logic [`HOST_AWIDTH-1:0]     pcie_address;
    logic                        pcie_write;
    logic                        pcie_read;
    logic [`HOST_DWIDTH-1:0]     pcie_writedata;
    logic [`HOST_DWIDTH/8-1:0]   pcie_byteenable;
    logic [`HOST_DWIDTH-1:0]     pcie_readdata;
    logic                        pcie_readdatavalid;
    logic [`STAT_AWIDTH-1:0]     status_addr;
    logic                        status_read;
    logic                        status_write;
    logic [31:0]                 status_writedata;
    logic [31:0]                 status_readdata;
    logic                        status_readdata_valid;
    logic                        dma_done;
    logic [31:0]                 new_tail;
    logic [3:0]                  curr_queue;
    logic [31:0]                 curr_head;
    logic [31:0]                 curr_tail;
    logic [63:0]                 curr_kmem_addr;
    logic                        switch_done;
    logic                        disable_pcie;
    logic [25:0]                 rb_size;

    // reference model state
    logic [31:0]  tbl [16][4];
    logic [31:0]  ctrl_m;
    int           cur_q;
    logic [31:0]  cur_e [4];
    logic [127:0] exp_host;
    logic [31:0]  exp_stat;

    integer seed = 32'h9f97;
    int     errors;
    int     test_start_errs;
    int     tests_run;
    int     tests_failed;

    pcie_queue_top UUT (.*);

    initial pcie_clk = 1'b0;
    always #50 pcie_clk = ~pcie_clk;

    function automatic logic [127:0] ref_entry(input int q);
        return {tbl[q][3], tbl[q][2], tbl[q][1], tbl[q][0]};
    endfunction

    // word 0 is the control register, word n the column (n-1)%4 of queue (n-1)/4
    function automatic logic [31:0] ref_status(input int n);
        if (n == 0) begin
            return ctrl_m;
        end
        return tbl[(n - 1) / 4][(n - 1) % 4];
    endfunction

    function automatic void model_host_write(input int q, input logic [127:0] d,
                                             input logic [15:0] be);
        for (int c = 1; c < 4; c++) begin
            if (&be[4*c +: 4]) begin
                tbl[q][c] = d[32*c +: 32];
                if (q == cur_q) begin
                    cur_e[c] = d[32*c +: 32];
                end
            end
        end
    endfunction

    function automatic void model_switch(input logic [31:0] tail);
        int nb;
        int nq;
        nb = int'(ctrl_m[31:27]);
        nq = (cur_q + 1 >= nb) ? 0 : cur_q + 1;
        for (int c = 1; c < 4; c++) begin
            cur_e[c] = tbl[nq][c];
        end
        // with one queue the table tail is stale
        cur_e[0] = (nb > 1) ? tbl[nq][0] : tail;
        tbl[cur_q][0] = tail;
        cur_q = nq;
    endfunction

    function automatic logic [19:0] page_addr(input int q);
        logic [19:0] a;
        a = '0;
        a[15:12] = q[3:0];
        return a;
    endfunction

    // compare process
    always @(posedge pcie_clk) begin
        if (pcie_readdatavalid) begin
            if (pcie_readdata !== exp_host) begin
                errors++;
                $display("Fail %0t: host read returned %h, expected %h",
                         $time, pcie_readdata, exp_host);
            end
        end
        if (status_readdata_valid) begin
            if (status_readdata !== exp_stat) begin
                errors++;
                $display("Fail %0t: status read returned %h, expected %h",
                         $time, status_readdata, exp_stat);
            end
        end
    end

    task automatic abort_wait(input string what);
        $display("Error: no %s before the timeout", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == test_start_errs) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests_run, name);
        end
        test_start_errs = errors;
    endtask

    task automatic host_write(input int q, input logic [127:0] d, input logic [15:0] be);
        @(posedge pcie_clk);
        pcie_address    <= page_addr(q);
        pcie_writedata  <= d;
        pcie_byteenable <= be;
        pcie_write      <= 1'b1;
        model_host_write(q, d, be);
        @(posedge pcie_clk);
        pcie_write <= 1'b0;
    endtask

    task automatic host_read(input int q);
        int n;
        @(posedge pcie_clk);
        exp_host     = ref_entry(q);
        pcie_address <= page_addr(q);
        pcie_read    <= 1'b1;
        @(posedge pcie_clk);
        pcie_read <= 1'b0;
        n = 1;
        while (!pcie_readdatavalid) begin
            if (n >= 40) begin
                abort_wait("pcie_readdatavalid");
            end
            @(posedge pcie_clk);
            n++;
        end
    endtask

    task automatic status_write_word(input int a, input logic [31:0] d);
        @(posedge pcie_clk);
        status_addr      <= a[7:0];
        status_writedata <= d;
        status_write     <= 1'b1;
        if (a == 0) begin
            ctrl_m = d;
        end
        @(posedge pcie_clk);
        status_write <= 1'b0;
        // let the register load
        repeat (2) @(posedge pcie_clk);
    endtask

    // optional host write to queue wq while the status read is pending
    task automatic status_read_word(input int a, input bit with_write, input int wq,
                                    input logic [127:0] wd, output int lat);
        @(posedge pcie_clk);
        exp_stat    = ref_status(a);
        status_addr <= a[7:0];
        status_read <= 1'b1;
        @(posedge pcie_clk);
        status_read <= 1'b0;
        lat = 1;
        if (with_write) begin
            // the write meets the cycle in which the arbiter would serve the status read
            repeat (2) begin
                @(posedge pcie_clk);
                lat++;
            end
            pcie_address    <= page_addr(wq);
            pcie_writedata  <= wd;
            pcie_byteenable <= '1;
            pcie_write      <= 1'b1;
            model_host_write(wq, wd, 16'hffff);
            @(posedge pcie_clk);
            pcie_write <= 1'b0;
            lat++;
        end
        while (!status_readdata_valid) begin
            if (lat >= 40) begin
                abort_wait("status_readdata_valid");
            end
            @(posedge pcie_clk);
            lat++;
        end
    endtask

    task automatic dma_switch(input logic [31:0] tail);
        int n;
        @(posedge pcie_clk);
        dma_done <= 1'b1;
        new_tail <= tail;
        @(posedge pcie_clk);
        dma_done <= 1'b0;
        n = 1;
        while (!switch_done) begin
            if (n >= 20) begin
                abort_wait("switch_done");
            end
            @(posedge pcie_clk);
            n++;
        end
        model_switch(tail);
        if (curr_queue !== cur_q[3:0] || curr_tail !== cur_e[0] ||
            curr_head !== cur_e[1] || curr_kmem_addr !== {cur_e[3], cur_e[2]}) begin
            errors++;
            $display("Fail %0t: active queue %0d tail %h head %h, expected %0d %h %h",
                     $time, curr_queue, curr_tail, curr_head, cur_q, cur_e[0], cur_e[1]);
        end
    endtask

    initial begin
        logic [31:0]  w;
        logic [127:0] d;
        logic [15:0]  be;
        int           q;
        int           a;
        int           lat;
        pcie_reset_n     = 1'b0;
        pcie_address     = '0;
        pcie_write       = 1'b0;
        pcie_read        = 1'b0;
        pcie_writedata   = '0;
        pcie_byteenable  = '0;
        status_addr      = '0;
        status_read      = 1'b0;
        status_write     = 1'b0;
        status_writedata = '0;
        dma_done         = 1'b0;
        new_tail         = '0;
        for (int i = 0; i < 16; i++) begin
            for (int c = 0; c < 4; c++) begin
                tbl[i][c] = '0;
            end
        end
        for (int c = 0; c < 4; c++) begin
            cur_e[c] = '0;
        end
        ctrl_m = '0;
        cur_q  = 0;
        errors = 0;
        test_start_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        exp_host = '0;
        exp_stat = '0;
        repeat (4) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;
        @(posedge pcie_clk);

        // control register round trip
        w = $random(seed);
        status_write_word(0, w);
        status_read_word(0, 1'b0, 0, '0, lat);
        if (lat != 3) begin
            errors++;
            $display("Fail %0t: control read latency %0d", $time, lat);
        end
        if (disable_pcie !== w[0] || rb_size !== w[26:1]) begin
            errors++;
            $display("Fail %0t: control fields do not match %h", $time, w);
        end
        close_test("control register");

        for (int i = 0; i < 8; i++) begin
            q = int'($random(seed) & 15);
            d = {$random(seed), $random(seed), $random(seed), $random(seed)};
            host_write(q, d, 16'hffff);
            host_read(q);
        end
        close_test("full entry write and read");

        for (int i = 0; i < 8; i++) begin
            q = int'($random(seed) & 15);
            d = {$random(seed), $random(seed), $random(seed), $random(seed)};
            w = $random(seed);
            // each dword fully enabled about half of the time, dword 0 included
            for (int c = 0; c < 4; c++) begin
                be[4*c +: 4] = w[c] ? 4'hf : w[4*c+4 +: 4];
            end
            host_write(q, d, be);
            host_read(q);
        end
        close_test("partial byte enables");

        for (int i = 0; i < 12; i++) begin
            a = 1 + int'($random(seed) & 63);
            q = ((a - 1) / 4 + 1 + int'($random(seed) & 7)) % 16;
            d = {$random(seed), $random(seed), $random(seed), $random(seed)};
            status_read_word(a, i[0], q, d, lat);
        end
        close_test("status column reads");

        status_write_word(0, {5'd3, 26'h100, 1'b0});
        for (int i = 0; i < 4; i++) begin
            dma_switch($random(seed));
        end
        for (int i = 0; i < 3; i++) begin
            host_read(i);
        end
        close_test("queue switching");

        d = {$random(seed), $random(seed), $random(seed), $random(seed)};
        host_write(cur_q, d, 16'hffff);
        lat = 0;
        while (lat < 10 && (curr_head !== cur_e[1] ||
                            curr_kmem_addr !== {cur_e[3], cur_e[2]})) begin
            @(posedge pcie_clk);
            lat++;
        end
        if (curr_head !== cur_e[1] || curr_kmem_addr !== {cur_e[3], cur_e[2]}) begin
            errors++;
            $display("Fail %0t: active entry not updated by host write", $time);
        end
        close_test("active queue update");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
